// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - verilog/memPkg.sv
      - verilog/writeEnCtr.sv
      - verilog/storeLanes.sv
      - verilog/byteRam.sv
      - verilog/loadExtend.sv
      - verilog/memStage.sv
  - target: test
    files:
      - verification/clkGen.sv
      - verification/memStageTb.sv

// File: src.f
verilog/memPkg.sv
verilog/writeEnCtr.sv
verilog/storeLanes.sv
verilog/byteRam.sv
verilog/loadExtend.sv
verilog/memStage.sv
verification/clkGen.sv
verification/memStageTb.sv

// File: verification/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
   parameter int HALF_PERIOD  = 50,   // ns
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // released away from the sampling edge
   end

endmodule

`default_nettype wire

// File: verification/memStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb;
   import memPkg::*;

   localparam int AW    = 10;
   localparam int BYTES = 4 << AW;

   logic        clk;
   logic        rst;
   memReq_t     req;
   byteEn_t     dataWe;
   byteEn_t     instrWe;
   logic [31:0] loadData;
   logic        loadValid;

   logic [7:0]  dataRef [BYTES];    // big-endian byte images of both RAMs
   logic [7:0]  instrRef [BYTES];
   logic [31:0] expQ [$];
   logic [31:0] expHead;
   int          pending;
   byteEn_t     expMask;
   byteEn_t     expDataWe;
   byteEn_t     expInstrWe;
   string       testName;
   int          checks;
   int          errors;
   int          testChecks0;
   int          testErrors0;

   clkGen #(.HALF_PERIOD(50), .RESET_CYCLES(4)) u_clkGen (.clk(clk), .rst(rst));

   memStage #(.ADDR_WIDTH(AW)) u_dut (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .dataWe    (dataWe),
      .instrWe   (instrWe),
      .loadData  (loadData),
      .loadValid (loadValid)
   );

   function automatic logic inData(input logic [31:0] a);
      return (a[31:30] == 2'b00) && a[28];
   endfunction

   function automatic logic inInstr(input logic [31:0] a);
      return (a[31:30] == 2'b00) && a[29];
   endfunction

   function automatic logic isLoad(input opcode_t op);
      return op == opLb || op == opLh || op == opLw || op == opLbu || op == opLhu;
   endfunction

   function automatic byteEn_t laneMask(input opcode_t op, input logic [1:0] off);
      case (op)
         opSb:    return {off == 2'd0, off == 2'd1, off == 2'd2, off == 2'd3};
         opSh:    return {~off[1], ~off[1], off[1], off[1]};
         opSw:    return 4'b1111;
         default: return 4'b0000;
      endcase
   endfunction

   assign expMask    = laneMask(req.opcode, req.addr[1:0]);
   assign expDataWe  = (!req.stall && inData(req.addr)) ? expMask : 4'b0000;
   assign expInstrWe = (!req.stall && req.privExec && inInstr(req.addr)) ? expMask : 4'b0000;

   function automatic logic [31:0] loadRef(input opcode_t op, input logic [31:0] addr);
      logic [AW+1:0] w;
      logic [7:0]    b [4];
      logic [7:0]    sel;
      logic [15:0]   h;
      w = {addr[AW+1:2], 2'b00};
      for (int k = 0; k < 4; k++) begin
         b[k] = inData(addr) ? dataRef[w + k] : instrRef[w + k];   // nibble 3 reads data
      end
      sel = b[addr[1:0]];
      h   = addr[1] ? {b[2], b[3]} : {b[0], b[1]};
      case (op)
         opLb:    return {{24{sel[7]}}, sel};
         opLbu:   return {24'd0, sel};
         opLh:    return {{16{h[15]}}, h};
         opLhu:   return {16'd0, h};
         opLw:    return {b[0], b[1], b[2], b[3]};
         default: return 32'd0;
      endcase
   endfunction

   task automatic putByte(input logic [AW+1:0] idx, input logic [7:0] val,
                          input logic toData, input logic toInstr);
      if (toData) dataRef[idx] = val;
      if (toInstr) instrRef[idx] = val;
   endtask

   task automatic storeRef(input opcode_t op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic priv);
      logic          toData;
      logic          toInstr;
      logic [AW+1:0] a;
      toData  = inData(addr);
      toInstr = inInstr(addr) && priv;
      a       = addr[AW+1:0];
      case (op)
         opSb: putByte(a, wdata[7:0], toData, toInstr);
         opSh: begin
            putByte({a[AW+1:2], a[1], 1'b0}, wdata[15:8], toData, toInstr);
            putByte({a[AW+1:2], a[1], 1'b1}, wdata[7:0], toData, toInstr);
         end
         opSw: begin
            for (int k = 0; k < 4; k++) begin
               putByte({a[AW+1:2], 2'(k)}, wdata[31-8*k -: 8], toData, toInstr);
            end
         end
         default: ;
      endcase
   endtask

   task automatic syncHead();
      pending = expQ.size();
      expHead = (pending > 0) ? expQ[0] : 32'd0;
   endtask

   // one request per falling edge
   task automatic issue(input opcode_t op, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic stall, input logic priv);
      @(negedge clk);
      req           = '0;
      req.opcode    = op;
      req.addr      = addr;
      req.storeData = wdata;
      req.stall     = stall;
      req.privExec  = priv;
      req.readEn    = isLoad(op);
      if (isLoad(op)) begin
         expQ.push_back(loadRef(op, addr));
         syncHead();
      end else if (!stall) begin
         storeRef(op, addr, wdata, priv);
      end
   endtask

   task automatic drainLoads();
      int waited;
      waited = 0;
      @(negedge clk);
      req = '0;
      while (expQ.size() != 0) begin
         if (waited == 16) begin
            $display("timeout: %0d loads in %s never got loadValid", expQ.size(), testName);
            $display("Simulation failed");
            $finish;
         end
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic startTest(input string name);
      testName    = name;
      testChecks0 = checks;
      testErrors0 = errors;
   endtask

   task automatic endTest();
      drainLoads();
      $display("test %-14s %0d checks, %0d errors", testName, checks - testChecks0,
               errors - testErrors0);
   endtask

   // enable check every cycle, load result pops the queue
   always @(posedge clk) begin
      if (!rst) begin
         checks++;
         if (loadValid && expQ.size() > 0) begin
            void'(expQ.pop_front());
            checks++;
            syncHead();
         end
      end
   end

   weMatch: assert property (@(posedge clk) disable iff (rst)
      dataWe == expDataWe && instrWe == expInstrWe)
      else begin
         errors++;
         $display("MISMATCH %s: we expected %h/%h actual %h/%h", testName, $sampled(expDataWe),
                  $sampled(expInstrWe), $sampled(dataWe), $sampled(instrWe));
      end

   loadMatch: assert property (@(posedge clk) disable iff (rst)
      loadValid |-> loadData == expHead)
      else begin
         errors++;
         $display("MISMATCH %s: load expected %h actual %h", testName, $sampled(expHead),
                  $sampled(loadData));
      end

   loadExpected: assert property (@(posedge clk) disable iff (rst) loadValid |-> pending > 0)
      else begin
         errors++;
         $display("%s: loadValid raised with no load outstanding", testName);
      end

   loadLatency: assert property (@(posedge clk) disable iff (rst) req.readEn |=> loadValid)
      else begin
         errors++;
         $display("%s: loadValid did not follow a read one cycle later", testName);
      end

   initial begin
      logic [31:0] addrs [8];
      logic [31:0] d;
      logic [31:0] a;
      logic [3:0]  outNib [5];
      opcode_t     op;
      int          waited;
      void'($urandom(2147));
      req      = '0;
      expHead  = 32'd0;
      pending  = 0;
      checks   = 0;
      errors   = 0;
      testName = "reset";
      waited   = 0;
      while (rst !== 1'b0) begin
         if (waited == 10) begin
            $display("timeout: reset was never released");
            $display("Simulation failed");
            $finish;
         end
         @(negedge clk);
         waited++;
      end

      startTest("wordRoundTrip");
      for (int i = 0; i < 8; i++) begin
         addrs[i] = {4'h1, 28'($urandom) & 28'h0000ffc};
         issue(opSw, addrs[i], $urandom, 1'b0, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         issue(opLw, addrs[i], 32'd0, 1'b0, 1'b0);   // back to back
      end
      endTest();

      startTest("byteStoreLoad");
      a = 32'h1000_0200;
      issue(opSw, a, 32'h1122_3344, 1'b0, 1'b0);
      for (int k = 0; k < 4; k++) begin
         d    = $urandom;
         d[7] = k[0];   // odd offsets get a negative byte
         issue(opSb, a + k, d, 1'b0, 1'b0);
         issue(opLw, a, 32'd0, 1'b0, 1'b0);
      end
      for (int k = 0; k < 4; k++) begin
         issue(opLb, a + k, 32'd0, 1'b0, 1'b0);
         issue(opLbu, a + k, 32'd0, 1'b0, 1'b0);
      end
      endTest();

      startTest("halfStoreLoad");
      a = 32'h1000_0300;
      issue(opSw, a, $urandom, 1'b0, 1'b0);
      issue(opSh, a, $urandom | 32'h8000, 1'b0, 1'b0);
      issue(opSh, a + 2, $urandom & 32'h7fff, 1'b0, 1'b0);
      issue(opLw, a, 32'd0, 1'b0, 1'b0);
      for (int k = 0; k < 4; k += 2) begin
         issue(opLh, a + k, 32'd0, 1'b0, 1'b0);
         issue(opLhu, a + k, 32'd0, 1'b0, 1'b0);
      end
      endTest();

      startTest("stall");
      a = 32'h1000_0400;
      issue(opSw, a, 32'hcafe_0001, 1'b0, 1'b1);
      issue(opSw, 32'h2000_0400, 32'h1234_5678, 1'b0, 1'b1);
      issue(opSw, a, 32'h0bad_0bad, 1'b1, 1'b1);
      issue(opSb, a + 1, 32'h0000_00ff, 1'b1, 1'b1);
      issue(opSw, 32'h2000_0400, 32'hdead_beef, 1'b1, 1'b1);
      issue(opLw, a, 32'd0, 1'b0, 1'b0);
      issue(opLw, 32'h2000_0400, 32'd0, 1'b0, 1'b0);
      endTest();

      startTest("instrRegion");
      issue(opSw, 32'h2000_0040, $urandom, 1'b0, 1'b1);
      issue(opSw, 32'h2000_0040, $urandom, 1'b0, 1'b0);   // no privilege, dropped
      issue(opSw, 32'h3000_0080, $urandom, 1'b0, 1'b1);   // lands in both RAMs
      issue(opSw, 32'h2000_0080, $urandom, 1'b0, 1'b1);
      issue(opLw, 32'h2000_0040, 32'd0, 1'b0, 1'b0);
      issue(opLw, 32'h3000_0080, 32'd0, 1'b0, 1'b0);
      issue(opLw, 32'h2000_0080, 32'd0, 1'b0, 1'b0);
      issue(opLw, 32'h1000_0080, 32'd0, 1'b0, 1'b0);
      endTest();

      startTest("outsideMap");
      issue(opSw, 32'h1000_0500, $urandom, 1'b0, 1'b1);
      issue(opSw, 32'h2000_0500, $urandom, 1'b0, 1'b1);
      outNib = '{4'h0, 4'h4, 4'h8, 4'hc, 4'hf};
      for (int n = 0; n < 5; n++) begin
         issue(opSw, {outNib[n], 28'h000_0500}, $urandom, 1'b0, 1'b1);
         issue(opSb, {outNib[n], 28'h000_0502}, $urandom, 1'b0, 1'b1);
      end
      for (int k = 0; k < 16; k++) begin
         do begin
            op = opcode_t'($urandom % 64);
         end while (isLoad(op) || op == opSb || op == opSh || op == opSw);
         issue(op, 32'h3000_0500 + k, $urandom, 1'b0, 1'b1);
      end
      issue(opLw, 32'h1000_0500, 32'd0, 1'b0, 1'b0);
      issue(opLw, 32'h2000_0500, 32'd0, 1'b0, 1'b0);
      endTest();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] addr,
   input  memPkg::byteEn_t       we,
   input  logic [31:0]           wdata,
   input  logic                  readEn,
   output logic [31:0]           rdata
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   logic [31:0] mem [DEPTH];   // contents are not reset

   // lane i of we covers bits 8*i+7 .. 8*i
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (we[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
   end

   // old data on a same-cycle write
   always_ff @(posedge clk) begin
      if (readEn) begin
         rdata <= mem[addr];
      end
   end

   weKnown: assert property (@(posedge clk) !$isunknown(we))
      else $error("byte write enable is unknown");

endmodule

`default_nettype wire

// File: verilog/loadExtend.sv
`timescale 1ns/1ps
`default_nettype none

module loadExtend (
   input  logic            clk,
   input  logic            rst,
   input  logic            readEn,
   input  memPkg::opcode_t opcode,
   input  logic [31:0]     addr,
   input  logic [31:0]     dataWord,
   input  logic [31:0]     instrWord,
   output logic [31:0]     loadData,
   output logic            loadValid
);
   import memPkg::*;

   opcode_t     opQ;
   logic [1:0]  offsetQ;
   logic        isDataQ;    // nibble 3 counts as data for loads
   logic        validQ;
   logic [31:0] word;
   logic [7:0]  byteSel;
   logic [15:0] halfSel;

   always_ff @(posedge clk) begin
      if (rst) begin
         validQ <= 1'b0;
      end else begin
         validQ <= readEn;
      end
   end

   // request fields line up with the RAM read data one cycle later
   always_ff @(posedge clk) begin
      if (readEn) begin
         opQ     <= opcode;
         offsetQ <= addr[1:0];
         isDataQ <= isDataRegion(addr[31:28]);
      end
   end

   assign word = isDataQ ? dataWord : instrWord;

   always_comb begin
      case (offsetQ)
         2'd0:    byteSel = word[31:24];   // big-endian
         2'd1:    byteSel = word[23:16];
         2'd2:    byteSel = word[15:8];
         default: byteSel = word[7:0];
      endcase
   end

   assign halfSel = offsetQ[1] ? word[15:0] : word[31:16];

   always_comb begin
      case (opQ)
         opLb:    loadData = {{24{byteSel[7]}}, byteSel};
         opLbu:   loadData = {24'd0, byteSel};
         opLh:    loadData = {{16{halfSel[15]}}, halfSel};
         opLhu:   loadData = {16'd0, halfSel};
         opLw:    loadData = word;
         default: loadData = 32'd0;
      endcase
   end

   assign loadValid = validQ;

   noSpuriousValid: assert property (@(posedge clk) disable iff (rst)
      !readEn |=> !loadValid)
      else $error("loadValid without a read request");

endmodule

`default_nettype wire

// File: verilog/memPkg.sv
`default_nettype none

package memPkg;

   typedef logic [5:0] opcode_t;   // MIPS primary opcode field

   // loads
   localparam opcode_t opLb  = 6'h20;
   localparam opcode_t opLh  = 6'h21;
   localparam opcode_t opLw  = 6'h23;
   localparam opcode_t opLbu = 6'h24;
   localparam opcode_t opLhu = 6'h25;

   // stores
   localparam opcode_t opSb = 6'h28;
   localparam opcode_t opSh = 6'h29;
   localparam opcode_t opSw = 6'h2b;

   // bit 3 is lane 31..24, big-endian byte offset 0
   typedef logic [3:0] byteEn_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [31:0] addr;
      logic [31:0] storeData;
      logic        stall;       // blocks all writes this cycle
      logic        privExec;    // pcE[30] of the executing instruction
      logic        readEn;
   } memReq_t;

   // nibbles 1 and 3
   function automatic logic isDataRegion(input logic [3:0] topNibble);
      return (topNibble[3:2] == 2'b00) && topNibble[0];
   endfunction

   // nibbles 2 and 3; nibble 3 overlaps with data
   function automatic logic isInstrRegion(input logic [3:0] topNibble);
      return (topNibble[3:2] == 2'b00) && topNibble[1];
   endfunction

endpackage

`default_nettype wire

// File: verilog/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
   parameter int ADDR_WIDTH = 10   // word-address bits per RAM
) (
   input  logic            clk,
   input  logic            rst,
   input  memPkg::memReq_t req,
   output memPkg::byteEn_t dataWe,
   output memPkg::byteEn_t instrWe,
   output logic [31:0]     loadData,
   output logic            loadValid
);

   logic [31:0] laneData;    // store data spread across lanes
   logic [31:0] dataWord;
   logic [31:0] instrWord;

   writeEnCtr u_writeEnCtr (
      .opcode   (req.opcode),
      .addr     (req.addr),
      .stall    (req.stall),
      .privExec (req.privExec),
      .dataWe   (dataWe),
      .instrWe  (instrWe)
   );

   storeLanes u_storeLanes (
      .opcode    (req.opcode),
      .storeData (req.storeData),
      .laneData  (laneData)
   );

   // both RAMs index with the word address from bit 2 up
   byteRam #(.ADDR_WIDTH(ADDR_WIDTH)) u_dataRam (
      .clk    (clk),
      .addr   (req.addr[ADDR_WIDTH+1:2]),
      .we     (dataWe),
      .wdata  (laneData),
      .readEn (req.readEn),
      .rdata  (dataWord)
   );

   byteRam #(.ADDR_WIDTH(ADDR_WIDTH)) u_instrRam (
      .clk    (clk),
      .addr   (req.addr[ADDR_WIDTH+1:2]),
      .we     (instrWe),
      .wdata  (laneData),
      .readEn (req.readEn),
      .rdata  (instrWord)
   );

   loadExtend u_loadExtend (
      .clk       (clk),
      .rst       (rst),
      .readEn    (req.readEn),
      .opcode    (req.opcode),
      .addr      (req.addr),
      .dataWord  (dataWord),
      .instrWord (instrWord),
      .loadData  (loadData),
      .loadValid (loadValid)
   );

endmodule

`default_nettype wire

// File: verilog/storeLanes.sv
`timescale 1ns/1ps
`default_nettype none

module storeLanes (
   input  memPkg::opcode_t opcode,
   input  logic [31:0]     storeData,
   output logic [31:0]     laneData
);
   import memPkg::*;

   // replicate so every lane carries the value; the enables pick the lane
   always_comb begin
      case (opcode)
         opSb: begin
            laneData = {4{storeData[7:0]}};    // byte on all four lanes
         end
         opSh: begin
            laneData = {2{storeData[15:0]}};   // half on both halves
         end
         default: begin
            laneData = storeData;              // SW, others are masked off
         end
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/writeEnCtr.sv
`timescale 1ns/1ps
`default_nettype none

module writeEnCtr (
   input  memPkg::opcode_t opcode,
   input  logic [31:0]     addr,
   input  logic            stall,
   input  logic            privExec,
   output memPkg::byteEn_t dataWe,
   output memPkg::byteEn_t instrWe
);
   import memPkg::*;

   byteEn_t    storeMask;   // lanes touched, before region and stall
   logic [1:0] byteOffset;
   logic [3:0] topNibble;
   logic       inData;
   logic       inInstr;

   assign byteOffset = addr[1:0];
   assign topNibble  = addr[31:28];
   assign inData     = isDataRegion(topNibble);
   assign inInstr    = isInstrRegion(topNibble) && privExec;   // needs pcE[30]

   always_comb begin
      case (opcode)
         opSb: begin
            storeMask = 4'b1000 >> byteOffset;   // offset 0 is the top lane
         end
         opSh: begin
            storeMask = byteOffset[1] ? 4'b0011 : 4'b1100;
         end
         opSw: begin
            storeMask = 4'b1111;
         end
         default: begin
            storeMask = 4'b0000;   // loads and everything else
         end
      endcase
   end

   // nibble 3 hits both regions, so both masks can be set at once
   always_comb begin
      dataWe  = 4'b0000;
      instrWe = 4'b0000;
      if (!stall) begin
         if (inData) begin
            dataWe = storeMask;
         end
         if (inInstr) begin
            instrWe = storeMask;
         end
      end
   end

   stallBlocksWrites: assert final (!stall || (dataWe == 4'b0000 && instrWe == 4'b0000))
      else $error("write enable raised during stall");

endmodule

`default_nettype wire
